// ==== logic/ddr_pad_pkg.sv ====
// Widths, vector types and structs shared by the DDR pad logic
// Two beats per memclk cycle, and the upper beat always goes first
`default_nettype none

package ddr_pad_pkg;

	localparam int ADDR_W = 13;	// Row or column address
	localparam int BANK_W = 2;
	localparam int DQ_W   = 32;	// Data pads per beat
	localparam int DQM_W  = 4;	// One mask bit per byte lane
	localparam int DQS_W  = 4;	// One strobe per byte lane
	localparam int BEATS  = 2;	// Beats per memclk cycle

	typedef logic [ADDR_W-1:0]      addr_t;
	typedef logic [BANK_W-1:0]      bank_t;
	typedef logic [DQ_W-1:0]        dq_t;
	typedef logic [DQM_W-1:0]       dqm_t;
	typedef logic [DQS_W-1:0]       dqs_t;
	typedef logic [BEATS*DQ_W-1:0]  burst_data_t;	// Upper half is the first beat
	typedef logic [BEATS*DQM_W-1:0] burst_mask_t;

	// Command as issued by the controller, active high
	typedef struct packed {
		logic  ras;
		logic  cas;
		logic  we;
		logic  cke;
		bank_t bank;
		addr_t addr;
	} cmd_t;

	// Command at the pins
	typedef struct packed {
		logic  ras_n;
		logic  cas_n;
		logic  we_n;
		logic  cke;
		bank_t bank;
		addr_t addr;
	} pad_cmd_t;

	typedef struct packed {
		burst_data_t data;
		burst_mask_t mask;
	} wr_beat_t;

endpackage

`default_nettype wire

// ==== logic/cmd_launch.sv ====
// Command and clock-enable launch, sampled on the rising edge of memclk
// Pins change on the falling edge, half a cycle after sampling
`timescale 1ns/1ps
`default_nettype none

module cmd_launch (
	input  wire logic              memclk,
	input  wire logic              rst,
	input  wire ddr_pad_pkg::cmd_t cmd,
	output ddr_pad_pkg::pad_cmd_t  pad_cmd
);

	ddr_pad_pkg::cmd_t cmd_q;	// Rising-edge capture stage

	always_ff @(posedge memclk) begin
		if (rst) begin
			cmd_q <= '0;	// Idle command, cke low
		end else begin
			cmd_q <= cmd;
		end
	end

	// Launch stage; the half cycle gives the pins hold margin
	always_ff @(negedge memclk) begin
		if (rst) begin
			pad_cmd.ras_n <= 1'b1;
			pad_cmd.cas_n <= 1'b1;
			pad_cmd.we_n  <= 1'b1;
			pad_cmd.cke   <= 1'b0;
			pad_cmd.bank  <= '0;
			pad_cmd.addr  <= '0;
		end else begin
			pad_cmd.ras_n <= ~cmd_q.ras;	// Active low at the pins
			pad_cmd.cas_n <= ~cmd_q.cas;
			pad_cmd.we_n  <= ~cmd_q.we;
			pad_cmd.cke   <= cmd_q.cke;
			pad_cmd.bank  <= cmd_q.bank;
			pad_cmd.addr  <= cmd_q.addr;
		end
	end

	// Both stages must have dropped the clock enable one cycle after reset
	a_cke_low_after_rst: assert property (
		@(posedge memclk) rst |=> !pad_cmd.cke
	);

endmodule

`default_nettype wire

// ==== logic/ddr_out_serializer.sv ====
// Two-beat to double-data-rate output, upper beat in the high phase of memclk
// Output mux is selected by memclk itself, so the clock tree must be balanced
// The last loaded word repeats every cycle until the next load
`timescale 1ns/1ps
`default_nettype none

module ddr_out_serializer #(
	parameter int WIDTH = 32
) (
	input  wire logic                                memclk,
	input  wire logic                                wr_ena,
	input  wire logic [ddr_pad_pkg::BEATS*WIDTH-1:0] word_in,
	output logic [WIDTH-1:0]                         beat_out
);

	logic [WIDTH-1:0] hi_q;	// Upper beat as loaded
	logic [WIDTH-1:0] lo_q;	// Lower beat as loaded
	logic [WIDTH-1:0] hi_fall;	// Retimed for the high phase
	logic [WIDTH-1:0] lo_rise;	// Retimed for the low phase

	// Load stage, holds its word while wr_ena is low
	always_ff @(posedge memclk) begin
		if (wr_ena) begin
			hi_q <= word_in[WIDTH +: WIDTH];
			lo_q <= word_in[0 +: WIDTH];
		end
	end

	// Upper beat settles half a cycle before it is shown
	always_ff @(negedge memclk) begin
		hi_fall <= hi_q;
	end

	// Lower beat changes at the rising edge, while the mux shows the upper one
	always_ff @(posedge memclk) begin
		lo_rise <= lo_q;
	end

	assign beat_out = memclk ? hi_fall : lo_rise;	// Each input is stable while selected

endmodule

`default_nettype wire

// ==== logic/write_enable_gen.sv ====
// Write output-enable window and write strobe, timed from the write enable
// dq_oe covers the falling edge of the load cycle up to two rising edges later
`timescale 1ns/1ps
`default_nettype none

module write_enable_gen (
	input  wire logic          memclk,
	input  wire logic          rst,
	input  wire logic          wr_ena,
	output logic               dq_oe,
	output ddr_pad_pkg::dqs_t  dqs_out
);

	logic wr_q;	// Rising-edge stage
	logic wr_fall;	// Half a cycle later
	logic wr_rise;	// One more half cycle, closes the window

	always_ff @(posedge memclk) begin
		if (rst) begin
			wr_q    <= 1'b0;
			wr_rise <= 1'b0;
		end else begin
			wr_q    <= wr_ena;
			wr_rise <= wr_fall;
		end
	end

	always_ff @(negedge memclk) begin
		if (rst) begin
			wr_fall <= 1'b0;
		end else begin
			wr_fall <= wr_q;
		end
	end

	assign dq_oe = wr_fall | wr_rise;	// Back-to-back enables merge the windows

	// One strobe pulse per write, in the high phase that carries the upper beat
	assign dqs_out = {ddr_pad_pkg::DQS_W{memclk & wr_fall}};

	a_dqs_inside_oe: assert property (
		@(negedge memclk) disable iff (rst) (dqs_out != '0) |-> dq_oe
	);

	// A sampled enable keeps the pads driven over the next two rising edges
	a_oe_window: assert property (
		@(posedge memclk) disable iff (rst) wr_q |-> dq_oe ##1 dq_oe
	);

endmodule

`default_nettype wire

// ==== logic/read_capture.sv ====
// Read capture on the data strobe, resynchronized into memclk
// strobe_rev is static, changing it while reading corrupts the capture
// Assumes strobe edges land roughly in phase with memclk
`timescale 1ns/1ps
`default_nettype none

module read_capture (
	input  wire logic             memclk,
	input  wire ddr_pad_pkg::dq_t dq_in,
	input  wire logic             dqs_in,
	input  wire logic             strobe_rev,
	output ddr_pad_pkg::burst_data_t rd_data
);

	logic strobe_p;	// Follows dqs_in, or its inverse with strobe_rev
	logic strobe_n;

	ddr_pad_pkg::dq_t cap_p;	// Taken on the rising edge of strobe_p
	ddr_pad_pkg::dq_t cap_n;	// Taken on the rising edge of strobe_n
	ddr_pad_pkg::dq_t sync_p;	// cap_p in the memclk domain
	ddr_pad_pkg::dq_t sync_n;	// cap_n in the memclk domain
	ddr_pad_pkg::burst_data_t sync_rev;	// Reordered word for strobe_rev

	assign strobe_p = dqs_in ^ strobe_rev;
	assign strobe_n = ~strobe_p;

	always_ff @(posedge strobe_p) begin
		cap_p <= dq_in;
	end

	always_ff @(posedge strobe_n) begin
		cap_n <= dq_in;
	end

	always_ff @(posedge memclk) begin
		sync_p <= cap_p;
	end

	always_ff @(negedge memclk) begin
		sync_n <= cap_n;
	end

	// With strobe_rev the rising-edge word sits in cap_n, and its
	// capture lands one falling edge later, so both halves wait here
	always_ff @(negedge memclk) begin
		sync_rev <= {sync_n, sync_p};
	end

	assign rd_data = strobe_rev ? sync_rev : {sync_p, sync_n};

endmodule

`default_nettype wire

// ==== logic/ddr_pad_top.sv ====
// DDR SDRAM pad logic without pad cells
// dq, dqs and dqm come out as separate out, enable and in ports for the pad ring
// Only strobe 0 is used for read capture
`timescale 1ns/1ps
`default_nettype none

module ddr_pad_top (
	input  wire logic                  memclk,
	input  wire logic                  rst,
	input  wire ddr_pad_pkg::cmd_t     cmd,
	input  wire ddr_pad_pkg::wr_beat_t wr,
	input  wire logic                  wr_ena,
	input  wire logic                  strobe_rev,
	output logic [1:0]                 mclk,
	output ddr_pad_pkg::pad_cmd_t      pad_cmd,
	output ddr_pad_pkg::dq_t           dq_out,
	output logic                       dq_oe,
	output ddr_pad_pkg::dqs_t          dqs_out,
	output ddr_pad_pkg::dqm_t          dqm_out,
	input  wire ddr_pad_pkg::dq_t      dq_in,
	input  wire logic                  dqs_in,
	output ddr_pad_pkg::burst_data_t   rd_data
);

	assign mclk = {~memclk, memclk};	// Differential pair, true clock on bit 0

	cmd_launch u_cmd_launch (
		.memclk  (memclk),
		.rst     (rst),
		.cmd     (cmd),
		.pad_cmd (pad_cmd)
	);

	ddr_out_serializer #(
		.WIDTH (ddr_pad_pkg::DQ_W)
	) u_dq_ser (
		.memclk   (memclk),
		.wr_ena   (wr_ena),
		.word_in  (wr.data),
		.beat_out (dq_out)
	);

	// Mask follows the data beat for beat
	ddr_out_serializer #(
		.WIDTH (ddr_pad_pkg::DQM_W)
	) u_dqm_ser (
		.memclk   (memclk),
		.wr_ena   (wr_ena),
		.word_in  (wr.mask),
		.beat_out (dqm_out)
	);

	write_enable_gen u_wr_en (
		.memclk  (memclk),
		.rst     (rst),
		.wr_ena  (wr_ena),
		.dq_oe   (dq_oe),
		.dqs_out (dqs_out)
	);

	read_capture u_rd_cap (
		.memclk     (memclk),
		.dq_in      (dq_in),
		.dqs_in     (dqs_in),
		.strobe_rev (strobe_rev),
		.rd_data    (rd_data)
	);

endmodule

`default_nettype wire

// ==== verification/ddr_pad_tb.sv ====
// Table-driven testbench for the DDR pad logic, each row takes six memclk cycles
// Memory model moves dq_in and dqs_in on different rising edges
`timescale 1ns/1ps
`default_nettype none

module ddr_pad_tb;

	localparam int CLK_PERIOD      = 40;
	localparam int N_FIXED         = 4;
	localparam int N_ROWS          = 16;
	localparam int WATCHDOG_CYCLES = N_ROWS * 8 + 20;

	typedef struct packed {
		ddr_pad_pkg::cmd_t     cmd;
		ddr_pad_pkg::wr_beat_t wr;
		logic                  rev;	// strobe_rev for the read
		ddr_pad_pkg::dq_t      rd_hi;	// Word at the rising strobe
		ddr_pad_pkg::dq_t      rd_lo;	// Word at the falling strobe
	} row_t;

	logic memclk = 1'b0;
	logic rst;
	ddr_pad_pkg::cmd_t        cmd;
	ddr_pad_pkg::wr_beat_t    wr;
	logic                     wr_ena;
	logic                     strobe_rev;
	logic [1:0]               mclk;
	ddr_pad_pkg::pad_cmd_t    pad_cmd;
	ddr_pad_pkg::dq_t         dq_out;
	logic                     dq_oe;
	ddr_pad_pkg::dqs_t        dqs_out;
	ddr_pad_pkg::dqm_t        dqm_out;
	ddr_pad_pkg::dq_t         dq_in;
	logic                     dqs_in;
	ddr_pad_pkg::burst_data_t rd_data;

	row_t   rows [N_ROWS];
	integer seed;
	int     check_count;
	int     error_count;

	ddr_pad_top uut (
		.memclk     (memclk),
		.rst        (rst),
		.cmd        (cmd),
		.wr         (wr),
		.wr_ena     (wr_ena),
		.strobe_rev (strobe_rev),
		.mclk       (mclk),
		.pad_cmd    (pad_cmd),
		.dq_out     (dq_out),
		.dq_oe      (dq_oe),
		.dqs_out    (dqs_out),
		.dqm_out    (dqm_out),
		.dq_in      (dq_in),
		.dqs_in     (dqs_in),
		.rd_data    (rd_data)
	);

	initial begin
		forever #(CLK_PERIOD / 2) memclk = ~memclk;
	end

	task automatic compare_value(input string what, input logic [63:0] actual,
			input logic [63:0] expected);
		check_count++;
		assert (actual === expected) else begin
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	function automatic row_t make_row(input ddr_pad_pkg::cmd_t c,
			input ddr_pad_pkg::burst_data_t d, input ddr_pad_pkg::burst_mask_t m,
			input logic rev, input ddr_pad_pkg::dq_t hi, input ddr_pad_pkg::dq_t lo);
		row_t r;
		r.cmd     = c;
		r.wr.data = d;
		r.wr.mask = m;
		r.rev     = rev;
		r.rd_hi   = hi;
		r.rd_lo   = lo;
		return r;
	endfunction

	task automatic build_rows();
		logic [31:0] rnd;
		// Command bits are ras, cas, we, cke, bank, addr
		rows[0] = make_row(ddr_pad_pkg::cmd_t'({4'b1111, 2'd3, 13'h1fff}),
			64'hffff_ffff_0000_0000, 8'hf0, 1'b0, 32'hffff_ffff, 32'h0000_0000);
		rows[1] = make_row(ddr_pad_pkg::cmd_t'({4'b0000, 2'd0, 13'h0000}),
			64'h0000_0000_ffff_ffff, 8'h0f, 1'b1, 32'h0000_0000, 32'hffff_ffff);
		rows[2] = make_row(ddr_pad_pkg::cmd_t'({4'b1000, 2'd1, 13'h0aaa}),
			64'haaaa_aaaa_5555_5555, 8'ha5, 1'b0, 32'h5555_5555, 32'haaaa_aaaa);
		rows[3] = make_row(ddr_pad_pkg::cmd_t'({4'b0111, 2'd2, 13'h1555}),
			64'h5555_5555_aaaa_aaaa, 8'h5a, 1'b1, 32'haaaa_aaaa, 32'h5555_5555);
		for (int i = N_FIXED; i < N_ROWS; i++) begin
			rnd = $random(seed);
			rows[i].cmd.ras  = rnd[0];
			rows[i].cmd.cas  = rnd[1];
			rows[i].cmd.we   = rnd[2];
			rows[i].cmd.cke  = rnd[3];
			rows[i].cmd.bank = rnd[5:4];
			rows[i].cmd.addr = rnd[18:6];
			rows[i].rev      = rnd[19];
			rows[i].wr.mask  = rnd[27:20];
			rnd = $random(seed);
			rows[i].wr.data[63:32] = rnd;
			rnd = $random(seed);
			rows[i].wr.data[31:0] = rnd;
			rnd = $random(seed);
			rows[i].rd_hi = rnd;
			rnd = $random(seed);
			rows[i].rd_lo = rnd;
		end
	endtask

	// Both beats of the held write word, high phase then low phase
	task automatic check_beats(input row_t r, input string phase_tag);
		#10;
		compare_value({"dq_out upper ", phase_tag}, 64'(dq_out), 64'(r.wr.data[63:32]));
		compare_value({"dqm_out upper ", phase_tag}, 64'(dqm_out), 64'(r.wr.mask[7:4]));
		#20;
		compare_value({"dq_out lower ", phase_tag}, 64'(dq_out), 64'(r.wr.data[31:0]));
		compare_value({"dqm_out lower ", phase_tag}, 64'(dqm_out), 64'(r.wr.mask[3:0]));
	endtask

	task automatic run_row(input row_t r);
		ddr_pad_pkg::pad_cmd_t exp_cmd;
		exp_cmd.ras_n = ~r.cmd.ras;	// Pins are active low
		exp_cmd.cas_n = ~r.cmd.cas;
		exp_cmd.we_n  = ~r.cmd.we;
		exp_cmd.cke   = r.cmd.cke;
		exp_cmd.bank  = r.cmd.bank;
		exp_cmd.addr  = r.cmd.addr;

		@(posedge memclk);	// Row inputs, sampled at the next edge
		cmd        <= r.cmd;
		wr         <= r.wr;
		wr_ena     <= 1'b1;
		strobe_rev <= r.rev;
		dq_in      <= r.rd_hi;

		@(posedge memclk);	// Sampling edge k, strobe rises
		wr_ena <= 1'b0;
		wr     <= ~r.wr;	// Different word, must not be loaded
		dqs_in <= 1'b1;
		#10;
		compare_value("dq_oe before window", 64'(dq_oe), 64'h0);
		#20;
		compare_value("pad_cmd", 64'(pad_cmd), 64'(exp_cmd));
		compare_value("dq_oe at falling edge k", 64'(dq_oe), 64'h1);
		compare_value("dqs_out low phase k", 64'(dqs_out), 64'h0);

		@(posedge memclk);	// Cycle k+1 carries the write beats
		dq_in <= r.rd_lo;
		#10;
		compare_value("dq_out upper", 64'(dq_out), 64'(r.wr.data[63:32]));
		compare_value("dqm_out upper", 64'(dqm_out), 64'(r.wr.mask[7:4]));
		compare_value("dq_oe high phase", 64'(dq_oe), 64'h1);
		compare_value("dqs_out high phase", 64'(dqs_out), 64'hf);
		compare_value("mclk high phase", 64'(mclk), 64'h1);	// True clock on bit 0
		#20;
		compare_value("dq_out lower", 64'(dq_out), 64'(r.wr.data[31:0]));
		compare_value("dqm_out lower", 64'(dqm_out), 64'(r.wr.mask[3:0]));
		compare_value("dq_oe low phase", 64'(dq_oe), 64'h1);
		compare_value("dqs_out low phase", 64'(dqs_out), 64'h0);
		compare_value("mclk low phase", 64'(mclk), 64'h2);

		@(posedge memclk);	// Strobe falls, window closed
		dqs_in <= 1'b0;
		#10;
		compare_value("dq_oe after window", 64'(dq_oe), 64'h0);
		compare_value("dqs_out after window", 64'(dqs_out), 64'h0);
		compare_value("dq_out upper hold k+2", 64'(dq_out), 64'(r.wr.data[63:32]));
		#20;
		compare_value("dq_out lower hold k+2", 64'(dq_out), 64'(r.wr.data[31:0]));

		@(posedge memclk);
		check_beats(r, "hold k+3");

		@(posedge memclk);	// Two cycles after the falling strobe
		#10;
		compare_value("rd_data", 64'(rd_data), {r.rd_hi, r.rd_lo});
	endtask

	initial begin
		seed        = 80;
		check_count = 0;
		error_count = 0;
		rst         <= 1'b1;
		cmd         <= '0;
		wr          <= '0;
		wr_ena      <= 1'b0;
		strobe_rev  <= 1'b0;
		dq_in       <= '0;
		dqs_in      <= 1'b0;
		build_rows();

		repeat (4) @(posedge memclk);
		rst <= 1'b0;
		#10;
		compare_value("cke after reset", 64'(pad_cmd.cke), 64'h0);
		compare_value("ras_n after reset", 64'(pad_cmd.ras_n), 64'h1);
		compare_value("cas_n after reset", 64'(pad_cmd.cas_n), 64'h1);
		compare_value("we_n after reset", 64'(pad_cmd.we_n), 64'h1);
		compare_value("dq_oe after reset", 64'(dq_oe), 64'h0);
		compare_value("dqs_out after reset", 64'(dqs_out), 64'h0);

		for (int i = 0; i < N_ROWS; i++) begin
			run_row(rows[i]);
		end

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the rows did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
logic/ddr_pad_pkg.sv
logic/cmd_launch.sv
logic/ddr_out_serializer.sv
logic/write_enable_gen.sv
logic/read_capture.sv
logic/ddr_pad_top.sv
verification/ddr_pad_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := ddr_pad_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
PASS_MSG  := SIMULATION PASSED

SOURCES := $(wildcard logic/*.sv) $(wildcard verification/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
